// File: buffer.sv
`timescale 1ns/1ps

module buffer
    import lc3b_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  lc3b_stage in_stage,
    output lc3b_stage out_stage
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_stage <= stage_bubble;
        end else if (load) begin
            out_stage <= in_stage;
        end
    end

endmodule : buffer

// File: cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // port A, instruction fetch
    input  logic       resp_a,
    input  lc3b_word   rdata_a,
    output logic       read_a,
    output lc3b_word   address_a,

    // port B, data
    input  logic       resp_b,
    input  lc3b_word   rdata_b,
    output logic       read_b,
    output logic       write_b,
    output logic [1:0] wmask_b,
    output lc3b_word   address_b,
    output lc3b_word   wdata_b
);

    logic      stall;
    logic      br_taken;

    lc3b_stage if_stage;
    lc3b_stage if_id;
    lc3b_stage id_stage;
    lc3b_stage id_ex;
    lc3b_stage ex_stage;
    lc3b_stage ex_mem;
    lc3b_stage mem_stage;
    lc3b_stage mem_wb;

    // any request without its resp freezes the whole pipe
    assign stall = (read_a && !resp_a) || ((read_b || write_b) && !resp_b);

    // word accesses only
    assign wmask_b = wmask_word;

    if_datapath if_dp (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .br_taken  (br_taken),
        .pc_br     (ex_mem.pc_br),
        .resp_a    (resp_a),
        .rdata_a   (rdata_a),
        .read_a    (read_a),
        .address_a (address_a),
        .out_stage (if_stage)
    );

    buffer if_id_buf (
        .clk       (clk),
        .reset     (reset),
        .load      (!stall),
        .in_stage  (if_stage),
        .out_stage (if_id)
    );

    // writeback goes straight from mem_wb into the register file
    id_datapath id_dp (
        .clk       (clk),
        .reset     (reset),
        .in_stage  (if_id),
        .wb_dest   (mem_wb.dest),
        .wb_data   (mem_wb.dest_data),
        .wb_load   (mem_wb.ctrl.load_regfile),
        .out_stage (id_stage)
    );

    buffer id_ex_buf (
        .clk       (clk),
        .reset     (reset),
        .load      (!stall),
        .in_stage  (id_stage),
        .out_stage (id_ex)
    );

    ex_datapath ex_dp (
        .in_stage  (id_ex),
        .out_stage (ex_stage)
    );

    buffer ex_mem_buf (
        .clk       (clk),
        .reset     (reset),
        .load      (!stall),
        .in_stage  (ex_stage),
        .out_stage (ex_mem)
    );

    mem_datapath mem_dp (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .in_stage  (ex_mem),
        .resp_b    (resp_b),
        .rdata_b   (rdata_b),
        .read_b    (read_b),
        .write_b   (write_b),
        .address_b (address_b),
        .wdata_b   (wdata_b),
        .br_taken  (br_taken),
        .out_stage (mem_stage)
    );

    buffer mem_wb_buf (
        .clk       (clk),
        .reset     (reset),
        .load      (!stall),
        .in_stage  (mem_stage),
        .out_stage (mem_wb)
    );

endmodule : cpu_datapath

// File: tb_lc3b_model.svh
`ifndef TB_LC3B_MODEL_SVH
`define TB_LC3B_MODEL_SVH

// random source stepped once per bit taken
logic [15:0] lfsr_state;

// fibonacci form with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic int take_bits(int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
endfunction

lc3b_word model_regs [8];
lc3b_nzp  model_cc;
lc3b_word model_mem [1024];
logic     model_halted;

// expected port B transfers in program order
logic     exp_write [$];
lc3b_word exp_addr [$];
lc3b_word exp_data [$];

function automatic lc3b_nzp nzp_of(lc3b_word value);
    if (value[15]) begin
        return 3'b100;
    end else if (value == 16'h0000) begin
        return 3'b010;
    end
    return 3'b001;
endfunction

// runs imem one instruction at a time up to the self-branch
task automatic run_model(int max_steps);
    lc3b_word pc;
    lc3b_word ir;
    lc3b_word operand;
    lc3b_word addr;
    lc3b_word target;
    lc3b_word result;
    logic     writes_reg;
    pc = 16'h0000;
    model_cc = 3'b010;
    model_halted = 1'b0;
    for (int r = 0; r < 8; r++) begin
        model_regs[r] = 16'h0000;
    end
    for (int step = 0; step < max_steps && !model_halted; step++) begin
        ir = imem[pc[9:1]];
        pc = pc + 16'd2;
        writes_reg = 1'b0;
        result = 16'h0000;
        operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
        addr = model_regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
        target = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
        case (ir[15:12])
            op_add: begin
                result = model_regs[ir[8:6]] + operand;
                writes_reg = 1'b1;
            end
            op_and: begin
                result = model_regs[ir[8:6]] & operand;
                writes_reg = 1'b1;
            end
            op_not: begin
                result = ~model_regs[ir[8:6]];
                writes_reg = 1'b1;
            end
            op_ldr: begin
                result = model_mem[addr[10:1]];
                writes_reg = 1'b1;
                exp_write.push_back(1'b0);
                exp_addr.push_back(addr);
                exp_data.push_back(result);
            end
            op_str: begin
                model_mem[addr[10:1]] = model_regs[ir[11:9]];
                exp_write.push_back(1'b1);
                exp_addr.push_back(addr);
                exp_data.push_back(model_regs[ir[11:9]]);
            end
            op_br: begin
                if ((ir[11:9] & model_cc) != 3'b000) begin
                    // taken branch onto itself ends the program
                    model_halted = (target == pc - 16'd2);
                    pc = target;
                end
            end
            default: begin
            end
        endcase
        if (writes_reg) begin
            model_regs[ir[11:9]] = result;
            model_cc = nzp_of(result);
        end
    end
endtask

`endif

// File: cpu_datapath_tb.sv
`timescale 1ns/1ps

module cpu_datapath_tb
    import lc3b_types::*;
();

    localparam int random_groups  = 40;
    localparam int timeout_cycles = 20000;

    logic       clk = 1'b0;
    logic       reset;
    logic       resp_a;
    lc3b_word   rdata_a;
    logic       read_a;
    lc3b_word   address_a;
    logic       resp_b;
    lc3b_word   rdata_b;
    logic       read_b;
    logic       write_b;
    logic [1:0] wmask_b;
    lc3b_word   address_b;
    lc3b_word   wdata_b;

    lc3b_word imem [512];
    lc3b_word dmem [1024];
    lc3b_word self_pc;
    int       errors;
    int       delay_a;
    int       delay_b;
    int       xfer_count;
    int       self_fetches;
    logic     b_stalled;

    `include "tb_lc3b_model.svh"

    cpu_datapath uut (
        .clk       (clk),
        .reset     (reset),
        .resp_a    (resp_a),
        .rdata_a   (rdata_a),
        .read_a    (read_a),
        .address_a (address_a),
        .resp_b    (resp_b),
        .rdata_b   (rdata_b),
        .read_b    (read_b),
        .write_b   (write_b),
        .wmask_b   (wmask_b),
        .address_b (address_b),
        .wdata_b   (wdata_b)
    );

    always #20 clk = ~clk;

    task automatic check_word(string name, lc3b_word expected, lc3b_word actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_mask(string name, logic [1:0] expected, logic [1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    // data pattern over the whole word index
    function automatic lc3b_word fill_word(int index);
        return lc3b_word'(index * 40503) ^ 16'h3c5a;
    endfunction

    function automatic lc3b_word alu_instr(lc3b_opcode op, int dr, int sr1, int imm, int low);
        return {op, 3'(dr), 3'(sr1), 1'(imm), 5'(low)};
    endfunction

    function automatic lc3b_word mem_instr(lc3b_opcode op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic lc3b_word br_instr(int nzp, int off);
        return {op_br, 3'(nzp), 9'(off)};
    endfunction

    // one real instruction every five words with nops in between
    task automatic build_program();
        int op;
        int dr;
        int sr1;
        int imm;
        int low;
        int off;
        int nzp;
        int k;
        for (int i = 0; i < 512; i++) begin
            imem[i] = 16'h0000;
        end
        // R7 points at the data area and R6 at the dump area
        imem[0] = mem_instr(op_ldr, 7, 0, 0);
        imem[5] = mem_instr(op_ldr, 6, 0, 1);
        for (int g = 2; g < random_groups + 2; g++) begin
            op  = take_bits(3);
            dr  = take_bits(3);
            sr1 = take_bits(3);
            imm = take_bits(1);
            low = take_bits(5);
            off = take_bits(6);
            nzp = take_bits(3);
            k   = take_bits(2);
            // R6 and R7 stay bases
            if (dr > 5) begin
                dr = dr - 3;
            end
            if (imm == 0) begin
                low = low % 8;
            end
            if (k == 0) begin
                k = 1;
            end
            // no target past the first dump group
            if (k > random_groups + 2 - g) begin
                k = random_groups + 2 - g;
            end
            case (op)
                0, 6:    imem[g * 5] = alu_instr(op_add, dr, sr1, imm, low);
                1:       imem[g * 5] = alu_instr(op_and, dr, sr1, imm, low);
                2:       imem[g * 5] = alu_instr(op_not, dr, sr1, 1, 31);
                3, 7:    imem[g * 5] = mem_instr(op_ldr, dr, 7, off);
                4:       imem[g * 5] = mem_instr(op_str, sr1, 7, off);
                default: imem[g * 5] = br_instr(nzp, 5 * k - 1);
            endcase
        end
        for (int j = 0; j < 8; j++) begin
            imem[(random_groups + 2 + j) * 5] = mem_instr(op_str, j, 6, j);
        end
        self_pc = lc3b_word'((random_groups + 10) * 10);
        imem[self_pc[9:1]] = br_instr(7, -1);
    endtask

    // port B transfer that completes at the coming rising edge
    task automatic compare_transfer();
        string tag;
        tag = $sformatf("transfer %0d", xfer_count);
        if (xfer_count >= exp_addr.size()) begin
            $display("port B transfer at address %h was not expected by the model", address_b);
            errors++;
        end else begin
            check_bit({tag, " write"}, exp_write[xfer_count], write_b);
            check_word({tag, " address"}, exp_addr[xfer_count], address_b);
            check_mask({tag, " wmask"}, 2'b11, wmask_b);
            if (exp_write[xfer_count]) begin
                check_word({tag, " data"}, exp_data[xfer_count], wdata_b);
            end
        end
        if (write_b) begin
            dmem[address_b[10:1]] = wdata_b;
        end else begin
            rdata_b = dmem[address_b[10:1]];
        end
        xfer_count++;
    endtask

    task automatic verify_reset_outputs(string phase);
        check_bit({phase, " read_b"}, 1'b0, read_b);
        check_bit({phase, " write_b"}, 1'b0, write_b);
        check_bit({phase, " read_a"}, 1'b1, read_a);
        check_word({phase, " address_a"}, 16'h0000, address_a);
    endtask

    // responders drive resp on the falling edge so it holds through the rising edge
    always @(negedge clk) begin
        resp_a = 1'b0;
        if (read_a) begin
            if (delay_a == 0) begin
                resp_a = 1'b1;
                rdata_a = imem[address_a[9:1]];
                delay_a = take_bits(2);
            end else begin
                delay_a--;
            end
        end
        resp_b = 1'b0;
        if (read_b || write_b) begin
            if (delay_b == 0) begin
                resp_b = 1'b1;
                compare_transfer();
                delay_b = take_bits(2);
            end else begin
                delay_b--;
            end
        end
        // a fetch only counts when the pipe moves
        b_stalled = (read_b || write_b) && !resp_b;
        if (resp_a && !b_stalled && address_a == self_pc) begin
            self_fetches++;
        end
    end

    initial begin
        int cycles;
        reset = 1'b1;
        resp_a = 1'b0;
        rdata_a = 16'h0000;
        resp_b = 1'b0;
        rdata_b = 16'h0000;
        errors = 0;
        delay_a = 0;
        delay_b = 0;
        xfer_count = 0;
        self_fetches = 0;
        b_stalled = 1'b0;
        lfsr_state = 16'd71;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        // base values loaded by the first two groups
        dmem[0] = 16'h0100;
        dmem[1] = 16'h0200;
        model_mem[0] = 16'h0100;
        model_mem[1] = 16'h0200;
        build_program();
        run_model(4000);
        if (!model_halted) begin
            $display("reference model did not reach the self-branch");
            errors++;
        end

        repeat (8) begin
            @(negedge clk);
            verify_reset_outputs("reset held");
        end
        reset = 1'b0;
        #10;
        verify_reset_outputs("first cycle after reset");

        // second fetch of the self-branch means it was taken
        cycles = 0;
        while (self_fetches < 2 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (self_fetches < 2) begin
            $display("timeout: self-branch not reached within %0d cycles", timeout_cycles);
            errors++;
        end
        check_word("transfer count", lc3b_word'(exp_addr.size()), lc3b_word'(xfer_count));

        $display("run finished: %0d errors, %0d port B transfers", errors, xfer_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : cpu_datapath_tb

// File: ex_datapath.sv
`timescale 1ns/1ps

module ex_datapath
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  lc3b_stage in_stage,
    output lc3b_stage out_stage
);

    lc3b_word instr;
    lc3b_word operand_a;
    lc3b_word operand_b;
    lc3b_word alu_out;

    assign instr     = in_stage.instruction;
    assign operand_a = in_stage.sr1_data;

    // second operand mux
    always_comb begin
        case (in_stage.ctrl.alumux_sel)
            alumux_imm5:    operand_b = sext_imm5(instr);
            // word offset for ldr/str
            alumux_offset6: operand_b = sext_offset6(instr) << 1;
            default:        operand_b = in_stage.sr2_data;
        endcase
    end

    always_comb begin
        case (in_stage.ctrl.aluop)
            alu_and:  alu_out = operand_a & operand_b;
            alu_not:  alu_out = ~operand_a;
            alu_pass: alu_out = operand_b;
            default:  alu_out = operand_a + operand_b;
        endcase
    end

    always_comb begin
        out_stage       = in_stage;
        out_stage.alu   = alu_out;
        // target relative to the incremented pc
        out_stage.pc_br = in_stage.pc + 16'd2 + (sext_offset9(instr) << 1);
    end

endmodule : ex_datapath

// File: id_datapath.sv
`timescale 1ns/1ps

module id_datapath
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  lc3b_stage in_stage,
    input  lc3b_reg   wb_dest,
    input  lc3b_word  wb_data,
    input  logic      wb_load,
    output lc3b_stage out_stage
);

    lc3b_word         instr;
    lc3b_control_word ctrl;
    lc3b_reg          sr2_sel;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;

    assign instr = in_stage.instruction;

    // control decode
    always_comb begin
        ctrl        = ctrl_nop;
        ctrl.opcode = instr_opcode(instr);
        case (instr_opcode(instr))
            op_add, op_and: begin
                ctrl.aluop        = (instr_opcode(instr) == op_add) ? alu_add : alu_and;
                ctrl.alumux_sel   = instr_imm_flag(instr) ? alumux_imm5 : alumux_reg;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_ldr: begin
                ctrl.alumux_sel     = alumux_offset6;
                ctrl.regfilemux_sel = regfilemux_mdr;
                ctrl.mem_read       = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end
            op_str: begin
                ctrl.alumux_sel = alumux_offset6;
                ctrl.mem_write  = 1'b1;
                ctrl.sr2mux_sel = sr2mux_dr;
            end
            op_br: begin
                ctrl.is_br = 1'b1;
            end
            // anything outside the subset runs as a nop
            default: begin
                ctrl = ctrl_nop;
            end
        endcase
    end

    // store data comes from the dr field
    assign sr2_sel = (ctrl.sr2mux_sel == sr2mux_dr) ? instr_dr(instr) : instr_sr2(instr);

    regfile rf (
        .clk     (clk),
        .reset   (reset),
        .load    (wb_load),
        .dest    (wb_dest),
        .in_data (wb_data),
        .sr1     (instr_sr1(instr)),
        .sr2     (sr2_sel),
        .sr1_out (sr1_data),
        .sr2_out (sr2_data)
    );

    always_comb begin
        out_stage          = in_stage;
        out_stage.ctrl     = ctrl;
        out_stage.dest     = instr_dr(instr);
        out_stage.sr1_data = sr1_data;
        out_stage.sr2_data = sr2_data;
    end

endmodule : id_datapath

// File: if_datapath.sv
`timescale 1ns/1ps

module if_datapath
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  logic      br_taken,
    input  lc3b_word  pc_br,
    input  logic      resp_a,
    input  lc3b_word  rdata_a,
    output logic      read_a,
    output lc3b_word  address_a,
    output lc3b_stage out_stage
);

    lc3b_word pc;
    lc3b_word pc_next;

    // pc mux
    always_comb begin
        if (br_taken) begin
            pc_next = pc_br;
        end else begin
            pc_next = pc + 16'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 16'h0000;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // fetch is requested every cycle
    assign read_a    = 1'b1;
    assign address_a = pc;

    always_comb begin
        out_stage             = stage_bubble;
        out_stage.instruction = rdata_a;
        out_stage.pc          = pc;
    end

    // fetch address must not move under a pending request
    a_fetch_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        (read_a && !resp_a) |=> $stable(address_a)
    );

endmodule : if_datapath

// File: lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    import lc3b_types::*;

    // second ALU operand
    typedef enum logic [1:0] {
        alumux_reg,
        alumux_imm5,
        alumux_offset6
    } alumux_sel_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_op_t;

    typedef enum logic {
        regfilemux_alu,
        regfilemux_mdr
    } regfilemux_sel_t;

    // STR reads its source register through the dr field
    typedef enum logic {
        sr2mux_sr2,
        sr2mux_dr
    } sr2mux_sel_t;

    typedef struct packed {
        lc3b_opcode      opcode;
        alu_op_t         aluop;
        alumux_sel_t     alumux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            load_cc;
        logic            mem_read;
        logic            mem_write;
        logic            is_br;
        sr2mux_sel_t     sr2mux_sel;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         instruction;
        lc3b_word         pc;
        lc3b_reg          dest;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_word         alu;
        lc3b_word         pc_br;
        lc3b_word         dest_data;
    } lc3b_stage;

    // all-zero control word acts as a nop
    localparam lc3b_control_word ctrl_nop = '0;
    localparam lc3b_stage stage_bubble = '0;
    localparam logic [1:0] wmask_word = 2'b11;

endpackage : lc3b_ctrl_pkg

// File: lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // ISA encodings of the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // instruction field helpers
    function automatic lc3b_opcode instr_opcode(lc3b_word instr);
        return lc3b_opcode'(instr[15:12]);
    endfunction

    function automatic lc3b_reg instr_dr(lc3b_word instr);
        return instr[11:9];
    endfunction

    function automatic lc3b_reg instr_sr1(lc3b_word instr);
        return instr[8:6];
    endfunction

    function automatic lc3b_reg instr_sr2(lc3b_word instr);
        return instr[2:0];
    endfunction

    // dr bits read as n/z/p on a branch
    function automatic lc3b_nzp instr_nzp(lc3b_word instr);
        return instr[11:9];
    endfunction

    function automatic logic instr_imm_flag(lc3b_word instr);
        return instr[5];
    endfunction

    function automatic lc3b_word sext_imm5(lc3b_word instr);
        return {{11{instr[4]}}, instr[4:0]};
    endfunction

    function automatic lc3b_word sext_offset6(lc3b_word instr);
        return {{10{instr[5]}}, instr[5:0]};
    endfunction

    function automatic lc3b_word sext_offset9(lc3b_word instr);
        return {{7{instr[8]}}, instr[8:0]};
    endfunction

endpackage : lc3b_types

// File: mem_datapath.sv
`timescale 1ns/1ps

module mem_datapath
    import lc3b_types::*, lc3b_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  lc3b_stage in_stage,
    input  logic      resp_b,
    input  lc3b_word  rdata_b,
    output logic      read_b,
    output logic      write_b,
    output lc3b_word  address_b,
    output lc3b_word  wdata_b,
    output logic      br_taken,
    output lc3b_stage out_stage
);

    lc3b_nzp  cc;
    lc3b_nzp  cc_next;
    logic     xfer_done;
    lc3b_word rdata_hold;
    lc3b_word mdr;
    lc3b_word dest_data;

    // transfer can finish while fetch still stalls the pipe,
    // so remember it and drop the request
    always_ff @(posedge clk) begin
        if (reset) begin
            xfer_done <= 1'b0;
        end else if (!stall) begin
            xfer_done <= 1'b0;
        end else if ((read_b || write_b) && resp_b) begin
            xfer_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_b && resp_b) begin
            rdata_hold <= rdata_b;
        end
    end

    assign read_b    = in_stage.ctrl.mem_read && !xfer_done;
    assign write_b   = in_stage.ctrl.mem_write && !xfer_done;
    assign address_b = in_stage.alu;
    assign wdata_b   = in_stage.sr2_data;

    assign mdr       = xfer_done ? rdata_hold : rdata_b;
    assign dest_data = (in_stage.ctrl.regfilemux_sel == regfilemux_mdr) ? mdr : in_stage.alu;

    // condition code from the value being written back
    always_comb begin
        cc_next[2] = dest_data[15];
        cc_next[1] = (dest_data == 16'h0000);
        cc_next[0] = !dest_data[15] && (dest_data != 16'h0000);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b010;
        end else if (in_stage.ctrl.load_cc && !stall) begin
            cc <= cc_next;
        end
    end

    assign br_taken = in_stage.ctrl.is_br && |(instr_nzp(in_stage.instruction) & cc);

    always_comb begin
        out_stage           = in_stage;
        out_stage.dest_data = dest_data;
    end

    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(read_b && write_b)
    );

    // base registers are kept word aligned by software
    a_addr_even: assert property (
        @(posedge clk) disable iff (reset)
        (read_b || write_b) |-> !address_b[0]
    );

endmodule : mem_datapath

// File: regfile.sv
`timescale 1ns/1ps

module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word in_data,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    output lc3b_word sr1_out,
    output lc3b_word sr2_out
);

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (load) begin
            regs[dest] <= in_data;
        end
    end

    // asynchronous reads
    assign sr1_out = regs[sr1];
    assign sr2_out = regs[sr2];

endmodule : regfile

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_datapath_tb \
    -f verilog.f \
    -o cpu_datapath_sim

./obj_dir/cpu_datapath_sim | tee sim.log

if grep -q -F '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verilog.f
+incdir+.
lc3b_types.sv
lc3b_ctrl_pkg.sv
regfile.sv
if_datapath.sv
id_datapath.sv
ex_datapath.sv
mem_datapath.sv
buffer.sv
cpu_datapath.sv
cpu_datapath_tb.sv
